//--- bnd_cfg.svh
`ifndef BND_CFG_SVH
`define BND_CFG_SVH

// number of dimensions, one vote counter each
`define BND_NUM_DIM 8

// bits per transposed word, one per vector
`define BND_WORD_W 32

// signed accumulator, covers +/-1024 plus tie preset
`define BND_ACC_W 16

// item count, 1 to 1024
`define BND_CNT_W 11

// remainder field, log2 of the word width
`define BND_REM_W 5

`endif

//--- bnd_pkg.sv
`include "bnd_cfg.svh"

package bnd_pkg;

    // bundle request, one per accepted start
    typedef struct packed {
        logic [`BND_CNT_W-1:0] item_count;
    } bnd_req_t;

    // word d carries dimension d for 32 consecutive vectors
    typedef logic [`BND_NUM_DIM-1:0][`BND_WORD_W-1:0] bnd_words_t;

    // per-word control, fanned out to every vote counter
    typedef struct packed {
        logic                  update;
        logic                  last_update;
        logic [`BND_REM_W-1:0] remainder;
    } bnd_step_t;

endpackage

//--- vote_selector.sv
`timescale 1ns/100ps

`include "bnd_cfg.svh"

module vote_selector (
    input  logic                  clk,
    input  logic                  update,
    input  logic                  last_update,
    input  logic [`BND_REM_W-1:0] remainder,
    input  logic                  result_bit,
    input  logic [`BND_REM_W-1:0] index,
    output logic signed [1:0]     sel_bit
);

    logic masked;

    // on the final word, bits from the remainder upward are padding
    always_comb begin
        masked = last_update && (remainder != '0) && (index >= remainder);
    end

    always_ff @(posedge clk) begin
        if (!update || masked) begin
            sel_bit <= 2'sd0;
        end else if (result_bit) begin
            // bit 1 votes against
            sel_bit <= -2'sd1;
        end else begin
            sel_bit <= 2'sd1;
        end
    end

endmodule

//--- vote_counter.sv
`timescale 1ns/100ps

`include "bnd_cfg.svh"

module vote_counter #(
    parameter int W = `BND_ACC_W
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  logic                   even_count,
    input  logic                   tie_bit,
    input  bnd_pkg::bnd_step_t     step,
    input  logic [`BND_WORD_W-1:0] result,
    output logic                   sign_bit
);

    logic signed [1:0]   sel [`BND_WORD_W];
    logic                update_d;
    logic signed [W-1:0] vote_sum;
    logic signed [W-1:0] acc;

    // one selector per vector slot of the word
    for (genvar k = 0; k < `BND_WORD_W; k++) begin : g_sel
        vote_selector i_sel (
            .clk        (clk),
            .update     (step.update),
            .last_update(step.last_update),
            .remainder  (step.remainder),
            .result_bit (result[k]),
            .index      (`BND_REM_W'(k)),
            .sel_bit    (sel[k])
        );
    end

    // selector outputs land one cycle after update
    always_ff @(posedge clk) begin
        if (rst) begin
            update_d <= 1'b0;
        end else begin
            update_d <= step.update;
        end
    end

    always_comb begin
        vote_sum = '0;
        for (int k = 0; k < `BND_WORD_W; k++) begin
            vote_sum = vote_sum + sel[k];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (clear) begin
            if (!even_count) begin
                // odd count cannot tie
                acc <= '0;
            end else if (tie_bit) begin
                // -1, a tie ends negative
                acc <= '1;
            end else begin
                acc <= W'(1);
            end
        end else if (update_d) begin
            acc <= acc + vote_sum;
        end
    end

    // negative sum means most vectors had a 1
    assign sign_bit = acc[W-1];

endmodule

//--- tie_lfsr.sv
`timescale 1ns/100ps

`include "bnd_cfg.svh"

module tie_lfsr (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    output logic [`BND_NUM_DIM-1:0] tie_bits
);

    localparam logic [15:0] SEED = 16'hACE1;

    // taps 16, 14, 13, 11 in right-shift Galois form
    localparam logic [15:0] TAPS = 16'hB400;

    logic [15:0] state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEED;
        end else if (advance) begin
            if (state[0]) begin
                state <= (state >> 1) ^ TAPS;
            end else begin
                state <= state >> 1;
            end
        end
    end

    // dimension d takes state bit d
    assign tie_bits = state[`BND_NUM_DIM-1:0];

endmodule

//--- bundle_ctrl.sv
`timescale 1ns/100ps

`include "bnd_cfg.svh"

module bundle_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  bnd_pkg::bnd_req_t  req,
    input  logic               word_valid,
    output bnd_pkg::bnd_step_t step,
    output logic               clear,
    output logic               even_count,
    output logic               busy,
    output logic               done
);

    localparam int WC_W = `BND_CNT_W - `BND_REM_W + 1;

    logic [`BND_CNT_W-1:0] count_q;
    logic [WC_W-1:0]       total_words;
    logic [WC_W-1:0]       word_cnt;
    logic                  start_ok;
    logic                  last_word;
    logic                  collect_q;
    logic                  drain_q;

    assign start_ok = start && !busy;

    // words = count / 32 rounded up
    always_comb begin
        total_words = WC_W'(count_q[`BND_CNT_W-1:`BND_REM_W])
                    + WC_W'(|count_q[`BND_REM_W-1:0]);
        last_word   = (word_cnt == total_words - 1'b1);
    end

    // words count only while collecting, so strays during drain drop out
    always_comb begin
        step.update      = word_valid && collect_q;
        step.last_update = step.update && last_word;
        step.remainder   = count_q[`BND_REM_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            count_q <= req.item_count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            collect_q  <= 1'b0;
            word_cnt   <= '0;
            clear      <= 1'b0;
            even_count <= 1'b0;
            drain_q    <= 1'b0;
            done       <= 1'b0;
        end else begin
            clear   <= start_ok;
            drain_q <= step.last_update;
            // second drain stage, accumulators settled
            done    <= drain_q;
            if (start_ok) begin
                even_count <= ~req.item_count[0];
                busy       <= 1'b1;
                collect_q  <= 1'b1;
                word_cnt   <= '0;
            end else begin
                if (step.update) begin
                    word_cnt <= word_cnt + 1'b1;
                end
                if (step.last_update) begin
                    collect_q <= 1'b0;
                end
                if (drain_q) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

//--- hv_bundler.sv
`timescale 1ns/100ps

`include "bnd_cfg.svh"

module hv_bundler (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  bnd_pkg::bnd_req_t       req,
    input  logic                    word_valid,
    input  bnd_pkg::bnd_words_t     words,
    output logic                    busy,
    output logic                    done,
    output logic [`BND_NUM_DIM-1:0] hv_out
);

    import bnd_pkg::*;

    bnd_step_t               step;
    logic                    clear;
    logic                    even_count;
    logic [`BND_NUM_DIM-1:0] tie_bits;

    bundle_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .req       (req),
        .word_valid(word_valid),
        .step      (step),
        .clear     (clear),
        .even_count(even_count),
        .busy      (busy),
        .done      (done)
    );

    // steps once per bundle, counters sample before the step
    tie_lfsr i_lfsr (
        .clk     (clk),
        .rst     (rst),
        .advance (clear),
        .tie_bits(tie_bits)
    );

    for (genvar d = 0; d < `BND_NUM_DIM; d++) begin : g_dim
        vote_counter #(
            .W(`BND_ACC_W)
        ) i_counter (
            .clk       (clk),
            .rst       (rst),
            .clear     (clear),
            .even_count(even_count),
            .tie_bit   (tie_bits[d]),
            .step      (step),
            .result    (words[d]),
            .sign_bit  (hv_out[d])
        );
    end

endmodule

//--- hv_bundler_checker.sv
`timescale 1ns/100ps

`include "bnd_cfg.svh"

module hv_bundler_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    start,
    input logic                    busy,
    input logic                    done,
    input logic [`BND_NUM_DIM-1:0] hv_out
);

    // failure tally, read at the end of the run
    int assert_failures = 0;

    done_one_cycle: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    ) else begin
        $error("done stayed high for more than one cycle");
        assert_failures++;
    end

    // done marks the end of busy and nothing else
    done_with_busy_fall: assert property (
        @(posedge clk) disable iff (rst) done == $fell(busy)
    ) else begin
        $error("done and the fall of busy are not in the same cycle");
        assert_failures++;
    end

    hv_out_held: assert property (
        @(posedge clk) disable iff (rst) (!busy && !start) |=> $stable(hv_out)
    ) else begin
        $error("hv_out changed while idle with no start");
        assert_failures++;
    end

    idle_after_reset: assert property (
        @(posedge clk) rst |=> !busy
    ) else begin
        $error("busy was high in the cycle after reset");
        assert_failures++;
    end

endmodule

bind hv_bundler hv_bundler_checker i_checker (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .done  (done),
    .hv_out(hv_out)
);

//--- hv_bundler_tb.sv
`timescale 1ns/100ps

`include "bnd_cfg.svh"

module hv_bundler_tb;

    import bnd_pkg::*;

    localparam int    DONE_LIMIT = 200;
    localparam int    IDLE_LIMIT = 50;
    localparam string STIM_FILE  = "hv_bundler_stim.txt";

    logic                    clk;
    logic                    rst;
    logic                    start;
    bnd_req_t                req;
    logic                    word_valid;
    bnd_words_t              words;
    logic                    busy;
    logic                    done;
    logic [`BND_NUM_DIM-1:0] hv_out;

    int seed;
    int checks;
    int mismatches;
    int other_errors;
    bit abort;

    hv_bundler i_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .req       (req),
        .word_valid(word_valid),
        .words     (words),
        .busy      (busy),
        .done      (done),
        .hv_out    (hv_out)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic compare_value(input string name, input logic [`BND_NUM_DIM-1:0] expected,
                                 input logic [`BND_NUM_DIM-1:0] actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic note_problem(input string what);
        other_errors++;
        abort = 1'b1;
        $display("%s, at time %0t", what, $time);
    endtask

    // callers sit on a falling edge and inputs are held for one full cycle
    task automatic pulse_start(input logic [`BND_CNT_W-1:0] count);
        start = 1'b1;
        req.item_count = count;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic pulse_word(input bnd_words_t value);
        words = value;
        word_valid = 1'b1;
        @(negedge clk);
        word_valid = 1'b0;
    endtask

    // a done pulse already present when the wait starts counts
    task automatic wait_for_done(input string name);
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            note_problem($sformatf("%s: done did not arrive within %0d cycles",
                                   name, DONE_LIMIT));
        end
    endtask

    task automatic wait_for_idle(input string name);
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            note_problem($sformatf("%s: busy stayed high for %0d cycles", name, IDLE_LIMIT));
        end
    endtask

    initial begin
        int                     fd;
        string                  line;
        string                  rest;
        string                  name;
        int                     n;
        int                     cnt;
        int                     stray;
        int                     words_left;
        int                     bundle;
        int                     gap;
        logic [`BND_WORD_W-1:0] w [`BND_NUM_DIM];
        logic [`BND_NUM_DIM-1:0] expected;
        bnd_words_t             packed_words;

        seed         = 76;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        abort        = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        req          = '0;
        word_valid   = 1'b0;
        words        = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            note_problem("the stimulus file could not be opened");
        end
        bundle     = 0;
        words_left = 0;
        stray      = 0;
        while (!abort && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            rest = line.substr(1, line.len() - 1);
            name = $sformatf("bundle %0d", bundle);
            case (line[0])
                "R": begin
                    n = $sscanf(rest, "%d %d", cnt, stray);
                    if (n != 2 || cnt < 1 || cnt > 1024 || words_left != 0) begin
                        note_problem($sformatf("%s: request record is malformed", name));
                    end else begin
                        wait_for_idle(name);
                        if (!abort) begin
                            if (stray != 0) begin
                                // strobe while idle and a quiet cycle before the start
                                packed_words = '1;
                                pulse_word(packed_words);
                                @(negedge clk);
                            end
                            pulse_start(cnt[`BND_CNT_W-1:0]);
                            if (stray != 0) begin
                                // second start lands while busy
                                pulse_start(`BND_CNT_W'(1));
                            end
                            words_left = (cnt + `BND_WORD_W - 1) / `BND_WORD_W;
                        end
                    end
                end
                "W": begin
                    n = $sscanf(rest, "%h %h %h %h %h %h %h %h",
                                w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                    if (n != `BND_NUM_DIM || words_left == 0) begin
                        note_problem($sformatf("%s: word record is malformed or extra", name));
                    end else begin
                        gap = $random(seed) & 3;
                        repeat (gap) @(negedge clk);
                        for (int d = 0; d < `BND_NUM_DIM; d++) begin
                            packed_words[d] = w[d];
                        end
                        pulse_word(packed_words);
                        words_left--;
                        if (words_left == 0 && stray != 0) begin
                            // strobe during the drain stages
                            packed_words = '1;
                            pulse_word(packed_words);
                        end
                    end
                end
                "E": begin
                    n = $sscanf(rest, "%h", expected);
                    if (n != 1 || words_left != 0) begin
                        note_problem($sformatf("%s: expected record is malformed or early", name));
                    end else begin
                        wait_for_done(name);
                        if (!abort) begin
                            compare_value(name, expected, hv_out);
                        end
                        bundle++;
                    end
                end
                default: begin
                    note_problem("the stimulus file holds an unknown record");
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (!abort && checks == 0) begin
            note_problem("no expected vector was checked");
        end
        repeat (5) @(negedge clk);

        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, other_errors, i_dut.i_checker.assert_failures);
        if (mismatches == 0 && other_errors == 0 && i_dut.i_checker.assert_failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- hv_bundler_stim.txt
# R <item_count> <stray>: start a bundle, stray 1 adds ignored strobes and a second start
# W <word d0> ... <word d7>: transposed words in hex, bit k is vector k of the word
# E <hv_out>: expected majority vector in hex, bit d is dimension d
R 32 0
W FFFFFFFF 00000000 FFFF0001 0000FFFE 80000001 7FFFFFFF F0F0F0F1 0F0F0F0E
E 65
R 96 1
W FFFFFFFF 00000000 FFFFFFFF FFFFFFFF 0F0F0F0F 00000000 AAAAAAAA AAAAAAAA
W FFFFFFFF 00000000 0000FFFF 0000FFFE 0F0F0F0F 00000001 55555555 55555555
W 00000000 FFFFFFFF 00000001 00000000 FFFFFFFF FFFFFFFE FFFF8000 00007FFF
E 55
R 45 0
W 000FFFFF 007FFFFF 00000000 FFFFFFFF 0000FFFF AAAAAAAA 55555555 FFFF0000
W FFFFE000 00000000 FFFFFFFF 00001FFF FFFFE03F 00001FFF FFFFE000 FFFFE0FF
E AA
R 7 1
W FFFFFF80 0000007F FFFFFF87 0000000F FFFFFF81 00000078 0000006F 0000001F
E EA
R 64 1
W FFFFFFFF 00000000 AAAAAAAA FFFF0000 0F0F0F0F 12345678 80000000 00000001
W 00000000 FFFFFFFF 55555555 0000FFFF F0F0F0F0 EDCBA987 7FFFFFFF FFFFFFFE
E 4E
R 2 0
W 00000001 FFFFFFFE FFFFFFFC 00000002 00000003 FFFFFFFD 00000001 FFFFFFFC
E 33
R 40 1
W FFFFFFFF 0000FFFF 000FFFFF FFFFFFFF FFFF0000 0000FFFF 0000FFFF 55555555
W FFFFFF00 FFFFFF0F FFFFFF00 00000000 0000000F FFFFFF00 FFFFFF07 FFFFFF0F
E 1B
R 33 0
W FFFF0000 FFFF0000 0000FFFF 0000FFFF FFFFFFFF 00000000 AAAAAAAA 55555555
W FFFFFFFE 00000001 FFFFFFFF 00000000 00000000 FFFFFFFF 00000001 FFFFFFFE
E 56
R 1 0
W 00000001 FFFFFFFE FFFFFFFF 00000000 00000001 FFFFFFFE 80000001 7FFFFFFE
E 55

//--- hv_bundler.f
+incdir+.
bnd_pkg.sv
vote_selector.sv
vote_counter.sv
tie_lfsr.sv
bundle_ctrl.sv
hv_bundler.sv
hv_bundler_checker.sv
hv_bundler_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := hv_bundler_tb
FILELIST  := hv_bundler.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
STIM      := hv_bundler_stim.txt
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
PASS_MSG  := Simulation completed successfully

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(STIM)
	./$(SIM_BIN) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
